//--- common/MemWbPkg.sv
/*
 * Shared definitions for the memory write-back unit
 * Width typedefs and derived sizes, execution-state constants,
 * circular flush-range check on active-list pointers
 */
package MemWbPkg;

    // Field widths
    localparam int PHY_REG_NUM_WIDTH     = 6;
    localparam int REG_DATA_WIDTH        = 32;
    localparam int ACTIVE_LIST_PTR_WIDTH = 5;
    localparam int EXEC_STATE_WIDTH      = 2;

    // Physical register number, 64 registers
    typedef logic [PHY_REG_NUM_WIDTH-1:0] PhyRegNum;

    // One register data word
    typedef logic [REG_DATA_WIDTH-1:0] RegData;

    // Active-list entry index, wraps at the end of the list
    typedef logic [ACTIVE_LIST_PTR_WIDTH-1:0] ActiveListPtr;

    // Execution state stored per active-list entry
    typedef logic [EXEC_STATE_WIDTH-1:0] ExecState;

    // Array sizes derived from the widths
    localparam int PHY_REG_COUNT    = 1 << PHY_REG_NUM_WIDTH;
    localparam int ACTIVE_LIST_SIZE = 1 << ACTIVE_LIST_PTR_WIDTH;

    // Execution states
    localparam ExecState EXEC_STATE_NOT_FINISHED = 2'd0;
    localparam ExecState EXEC_STATE_SUCCESS      = 2'd1;
    localparam ExecState EXEC_STATE_REFETCH_THIS = 2'd2;
    localparam ExecState EXEC_STATE_FAULT        = 2'd3;

    // True when ptr lies in [head, tail) on the circular list
    // Equal head and tail give an empty range
    function automatic logic inFlushRange(
        input ActiveListPtr head,
        input ActiveListPtr tail,
        input ActiveListPtr ptr
    );
        logic inRange;
        if (head == tail) begin
            inRange = 1'b0;
        end else if (head < tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end else begin
            // Range wraps past the last entry
            inRange = (ptr >= head) || (ptr < tail);
        end
        return inRange;
    endfunction

endpackage

//--- hw/memWriteback/MemWritebackLane.sv
/*
 * One memory write-back lane
 * Pipeline register, selective flush check,
 * register file and active-list write ports
 */
`timescale 1ns/1ps

module MemWritebackLane (
    input  logic                   ctrl,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   clear,
    input  logic                   recoveryPhase,
    input  MemWbPkg::ActiveListPtr flushHead,
    input  MemWbPkg::ActiveListPtr flushTail,
    input  logic                   inValid,
    input  MemWbPkg::ActiveListPtr inAlPtr,
    input  logic                   inDstWrite,
    input  MemWbPkg::PhyRegNum     inDstReg,
    input  MemWbPkg::RegData       inData,
    input  MemWbPkg::ExecState     inExecState,
    input  logic                   inIsStore,
    output logic                   regWe,
    output MemWbPkg::PhyRegNum     regNum,
    output MemWbPkg::RegData       regData,
    output logic                   alWe,
    output MemWbPkg::ActiveListPtr alPtr,
    output MemWbPkg::ExecState     alState,
    output logic                   alIsStore
);
    import MemWbPkg::*;

    logic         pipeValid;
    ActiveListPtr pipeAlPtr;
    logic         pipeDstWrite;
    PhyRegNum     pipeDstReg;
    RegData       pipeData;
    ExecState     pipeExecState;
    logic         pipeIsStore;

    logic flush;
    logic update;

    always_ff @(posedge ctrl) begin
        if (rst) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= inValid;
        end
    end

    // Payload fields, held along with the valid bit
    always_ff @(posedge ctrl) begin
        if (!stall) begin
            pipeAlPtr     <= inAlPtr;
            pipeDstWrite  <= inDstWrite;
            pipeDstReg    <= inDstReg;
            pipeData      <= inData;
            pipeExecState <= inExecState;
            pipeIsStore   <= inIsStore;
        end
    end

    // Drop items younger than the recovery point
    assign flush  = recoveryPhase && inFlushRange(flushHead, flushTail, pipeAlPtr);
    assign update = pipeValid && !stall && !clear && !flush;

    assign alWe      = update;
    assign alPtr     = pipeAlPtr;
    assign alIsStore = pipeIsStore;
    assign alState   = update ? pipeExecState : EXEC_STATE_NOT_FINISHED;

    assign regWe   = update && pipeDstWrite;
    assign regNum  = pipeDstReg;
    assign regData = pipeData;

    // A register write always comes with its active-list update
    assert property (@(posedge ctrl) disable iff (rst) regWe |-> alWe);

    // Held items stay out of the recorder until stall drops
    assert property (@(posedge ctrl) disable iff (rst) stall |-> (!regWe && !alWe));

endmodule

//--- hw/memWriteback/RecoveryManager.sv
/*
 * Recovery manager
 * Latches the flush range and holds the recovery phase
 * for a fixed number of cycles
 */
`timescale 1ns/1ps

module RecoveryManager #(
    parameter int RECOVERY_CYCLES = 3
) (
    input  logic                   ctrl,
    input  logic                   rst,
    input  logic                   recoveryReq,
    input  MemWbPkg::ActiveListPtr recoveryHead,
    input  MemWbPkg::ActiveListPtr recoveryTail,
    output logic                   recoveryPhase,
    output MemWbPkg::ActiveListPtr flushHead,
    output MemWbPkg::ActiveListPtr flushTail,
    output logic                   recoveryBusy
);
    import MemWbPkg::*;

    localparam int COUNT_WIDTH = $clog2(RECOVERY_CYCLES + 1);

    typedef enum logic {
        IDLE,
        RECOVER
    } RecoveryState;

    RecoveryState             state;
    logic [COUNT_WIDTH-1:0]   count;

    always_ff @(posedge ctrl) begin
        if (rst) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (recoveryReq) begin
                        state <= RECOVER;
                        count <= COUNT_WIDTH'(RECOVERY_CYCLES - 1);
                    end
                end
                RECOVER: begin
                    // Requests while busy are dropped
                    if (count == '0) begin
                        state <= IDLE;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Range captured only when a request is accepted
    always_ff @(posedge ctrl) begin
        if (state == IDLE && recoveryReq) begin
            flushHead <= recoveryHead;
            flushTail <= recoveryTail;
        end
    end

    assign recoveryPhase = (state == RECOVER);
    assign recoveryBusy  = (state == RECOVER);

    assert property (@(posedge ctrl) disable iff (rst) int'(count) < RECOVERY_CYCLES);

endmodule

//--- hw/memWriteback/CompletionRecorder.sv
/*
 * Completion recorder
 * Physical register array and active-list state array,
 * per-lane write ports and combinational read ports
 */
`timescale 1ns/1ps

module CompletionRecorder #(
    parameter int LANE_COUNT = 2
) (
    input  logic                   ctrl,
    input  logic                   rst,
    input  logic                   regWe     [LANE_COUNT],
    input  MemWbPkg::PhyRegNum     regNum    [LANE_COUNT],
    input  MemWbPkg::RegData       regData   [LANE_COUNT],
    input  logic                   alWe      [LANE_COUNT],
    input  MemWbPkg::ActiveListPtr alPtr     [LANE_COUNT],
    input  MemWbPkg::ExecState     alState   [LANE_COUNT],
    input  logic                   alIsStore [LANE_COUNT],
    input  MemWbPkg::PhyRegNum     regReadNum,
    output MemWbPkg::RegData       regReadData,
    input  MemWbPkg::ActiveListPtr alReadPtr,
    output MemWbPkg::ExecState     alReadState,
    output logic                   alReadIsStore
);
    import MemWbPkg::*;

    RegData   phyRegs      [PHY_REG_COUNT];
    ExecState entryState   [ACTIVE_LIST_SIZE];
    logic     entryIsStore [ACTIVE_LIST_SIZE];

    always_ff @(posedge ctrl) begin
        if (rst) begin
            for (int r = 0; r < PHY_REG_COUNT; r++) begin
                phyRegs[r] <= '0;
            end
            for (int e = 0; e < ACTIVE_LIST_SIZE; e++) begin
                entryState[e]   <= EXEC_STATE_NOT_FINISHED;
                entryIsStore[e] <= 1'b0;
            end
        end else begin
            // Later lanes override earlier ones on the same register
            for (int i = 0; i < LANE_COUNT; i++) begin
                if (regWe[i]) begin
                    phyRegs[regNum[i]] <= regData[i];
                end
                if (alWe[i]) begin
                    entryState[alPtr[i]]   <= alState[i];
                    entryIsStore[alPtr[i]] <= alIsStore[i];
                end
            end
        end
    end

    assign regReadData   = phyRegs[regReadNum];
    assign alReadState   = entryState[alReadPtr];
    assign alReadIsStore = entryIsStore[alReadPtr];

    // Each active-list entry belongs to one instruction, so one lane at a time
    for (genvar i = 0; i < LANE_COUNT; i++) begin : gAlCheck
        for (genvar j = i + 1; j < LANE_COUNT; j++) begin : gPair
            assert property (@(posedge ctrl) disable iff (rst)
                !(alWe[i] && alWe[j] && alPtr[i] == alPtr[j]));
        end
    end

endmodule

//--- hw/MemWritebackUnit.sv
/*
 * Memory write-back unit top level
 * Recovery manager, write-back lanes, completion recorder
 */
`timescale 1ns/1ps

module MemWritebackUnit #(
    parameter int LANE_COUNT      = 2,
    parameter int RECOVERY_CYCLES = 3
) (
    input  logic                   ctrl,
    input  logic                   rst,
    input  logic                   inValid     [LANE_COUNT],
    input  MemWbPkg::ActiveListPtr inAlPtr     [LANE_COUNT],
    input  logic                   inDstWrite  [LANE_COUNT],
    input  MemWbPkg::PhyRegNum     inDstReg    [LANE_COUNT],
    input  MemWbPkg::RegData       inData      [LANE_COUNT],
    input  MemWbPkg::ExecState     inExecState [LANE_COUNT],
    input  logic                   inIsStore   [LANE_COUNT],
    input  logic                   stall,
    input  logic                   clear,
    input  logic                   recoveryReq,
    input  MemWbPkg::ActiveListPtr recoveryHead,
    input  MemWbPkg::ActiveListPtr recoveryTail,
    input  MemWbPkg::PhyRegNum     regReadNum,
    output MemWbPkg::RegData       regReadData,
    input  MemWbPkg::ActiveListPtr alReadPtr,
    output MemWbPkg::ExecState     alReadState,
    output logic                   alReadIsStore,
    output logic                   recoveryBusy
);
    import MemWbPkg::*;

    logic         recoveryPhase;
    ActiveListPtr flushHead;
    ActiveListPtr flushTail;

    // Lane write ports into the recorder
    logic         regWe     [LANE_COUNT];
    PhyRegNum     regNum    [LANE_COUNT];
    RegData       regData   [LANE_COUNT];
    logic         alWe      [LANE_COUNT];
    ActiveListPtr alPtr     [LANE_COUNT];
    ExecState     alState   [LANE_COUNT];
    logic         alIsStore [LANE_COUNT];

    RecoveryManager #(
        .RECOVERY_CYCLES(RECOVERY_CYCLES)
    ) recoveryManager (
        .ctrl         (ctrl),
        .rst          (rst),
        .recoveryReq  (recoveryReq),
        .recoveryHead (recoveryHead),
        .recoveryTail (recoveryTail),
        .recoveryPhase(recoveryPhase),
        .flushHead    (flushHead),
        .flushTail    (flushTail),
        .recoveryBusy (recoveryBusy)
    );

    for (genvar i = 0; i < LANE_COUNT; i++) begin : gLane
        MemWritebackLane lane (
            .ctrl         (ctrl),
            .rst          (rst),
            .stall        (stall),
            .clear        (clear),
            .recoveryPhase(recoveryPhase),
            .flushHead    (flushHead),
            .flushTail    (flushTail),
            .inValid      (inValid[i]),
            .inAlPtr      (inAlPtr[i]),
            .inDstWrite   (inDstWrite[i]),
            .inDstReg     (inDstReg[i]),
            .inData       (inData[i]),
            .inExecState  (inExecState[i]),
            .inIsStore    (inIsStore[i]),
            .regWe        (regWe[i]),
            .regNum       (regNum[i]),
            .regData      (regData[i]),
            .alWe         (alWe[i]),
            .alPtr        (alPtr[i]),
            .alState      (alState[i]),
            .alIsStore    (alIsStore[i])
        );
    end

    CompletionRecorder #(
        .LANE_COUNT(LANE_COUNT)
    ) completionRecorder (
        .ctrl         (ctrl),
        .rst          (rst),
        .regWe        (regWe),
        .regNum       (regNum),
        .regData      (regData),
        .alWe         (alWe),
        .alPtr        (alPtr),
        .alState      (alState),
        .alIsStore    (alIsStore),
        .regReadNum   (regReadNum),
        .regReadData  (regReadData),
        .alReadPtr    (alReadPtr),
        .alReadState  (alReadState),
        .alReadIsStore(alReadIsStore)
    );

endmodule

//--- verification/TbClock.sv
/* Testbench clock and synchronous reset generator */
`timescale 1ns/1ps

module TbClock #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic ctrl,
    output logic rst
);
    initial begin
        ctrl = 1'b0;
        forever #(PERIOD_NS / 2) ctrl = ~ctrl;
    end

    // Reset drops on a rising edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge ctrl);
        rst <= 1'b0;
    end

endmodule

//--- verification/TbMemWriteback.sv
/*
 * Testbench for the memory write-back unit
 * Directed and random stimulus, reference model of both arrays,
 * read-back compare through the read ports, recovery busy check, watchdog
 */
`timescale 1ns/1ps

module TbMemWriteback;
    import MemWbPkg::*;

    localparam int LANES       = 2;
    localparam int REC_CYCLES  = 3;
    localparam int TEST_CYCLES = 16 + 6 * (PHY_REG_COUNT + 3) + 200 + 60;

    logic         ctrl, rst, recoveryBusy, alReadIsStore;
    logic         stall = 1'b0, clear = 1'b0, recoveryReq = 1'b0;
    ActiveListPtr recoveryHead = '0, recoveryTail = '0, alReadPtr = '0;
    PhyRegNum     regReadNum = '0;
    RegData       regReadData;
    ExecState     alReadState;
    logic         inValid [LANES] = '{default: '0}, inDstWrite [LANES] = '{default: '0};
    logic         inIsStore [LANES] = '{default: '0};
    ActiveListPtr inAlPtr [LANES] = '{default: '0};
    PhyRegNum     inDstReg [LANES] = '{default: '0};
    RegData       inData [LANES] = '{default: '0};
    ExecState     inExecState [LANES] = '{default: '0};

    // Reference arrays, lane pipeline copies and recovery window
    RegData       refRegs [PHY_REG_COUNT];
    ExecState     refState [ACTIVE_LIST_SIZE];
    logic         refIsStore [ACTIVE_LIST_SIZE];
    logic         pValid [LANES], pDst [LANES], pStore [LANES];
    ActiveListPtr pPtr [LANES], recHead, recTail;
    PhyRegNum     pReg [LANES];
    RegData       pData [LANES];
    ExecState     pState [LANES];
    int           recCount;
    int           errorCount = 0;
    logic [31:0]  lcgState = 32'd11414;
    logic         checkBusy = 1'b0;

    TbClock clockGen (.*);

    MemWritebackUnit #(
        .LANE_COUNT     (LANES),
        .RECOVERY_CYCLES(REC_CYCLES)
    ) i_dut (.*);

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Valid, not stalled, not cleared, and outside an open flush window
    function automatic logic expectUpdate(int lane);
        ActiveListPtr offset;
        ActiveListPtr span;
        offset = pPtr[lane] - recHead;
        span   = recTail - recHead;
        return pValid[lane] && !stall && !clear && !(recCount > 0 && offset < span);
    endfunction

    always @(posedge ctrl) begin
        if (rst) begin
            refRegs    = '{default: '0};
            refState   = '{default: EXEC_STATE_NOT_FINISHED};
            refIsStore = '{default: 1'b0};
            pValid     = '{default: 1'b0};
            recCount   = 0;
        end else begin
            for (int i = 0; i < LANES; i++) begin
                if (expectUpdate(i)) begin
                    refState[pPtr[i]]   = pState[i];
                    refIsStore[pPtr[i]] = pStore[i];
                    if (pDst[i]) begin
                        refRegs[pReg[i]] = pData[i];
                    end
                end
            end
            if (!stall) begin
                pValid = inValid;
                pPtr   = inAlPtr;
                pDst   = inDstWrite;
                pReg   = inDstReg;
                pData  = inData;
                pState = inExecState;
                pStore = inIsStore;
            end
            // Window covers the REC_CYCLES cycles after an accepted request
            if (recCount > 0) begin
                recCount--;
            end else if (recoveryReq) begin
                recCount = REC_CYCLES;
                recHead  = recoveryHead;
                recTail  = recoveryTail;
            end
        end
    end

    task automatic checkRegData(string name, RegData got, RegData exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkExecState(string name, ExecState got, ExecState exp,
                                  logic gotStore, logic expStore);
        if (got !== exp || gotStore !== expStore) begin
            errorCount++;
            $display("ERROR %s: got state %h isStore %h, expected state %h isStore %h",
                     name, got, gotStore, exp, expStore);
        end
    endtask

    task automatic checkRecoveryBusy(string name, logic got, logic exp);
        if (got !== exp) begin
            errorCount++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Busy follows the recovery window of the reference model
    always @(negedge ctrl) begin
        if (!rst) begin
            checkRecoveryBusy("recoveryBusy", recoveryBusy, recCount > 0);
        end
    end

    // Walks both arrays through the read ports on request
    initial begin
        forever begin
            wait (checkBusy);
            for (int k = 0; k < PHY_REG_COUNT; k++) begin
                @(posedge ctrl);
                regReadNum <= PhyRegNum'(k);
                alReadPtr  <= ActiveListPtr'(k);
                @(negedge ctrl);
                checkRegData($sformatf("regReadData[%0d]", k), regReadData, refRegs[k]);
                if (k < ACTIVE_LIST_SIZE) begin
                    checkExecState($sformatf("alReadState[%0d]", k), alReadState,
                                   refState[k], alReadIsStore, refIsStore[k]);
                end
            end
            checkBusy = 1'b0;
        end
    end

    task automatic presentItem(int lane, ActiveListPtr ptr, logic dst, PhyRegNum dstReg,
                               RegData data, ExecState state, logic isStore);
        inValid[lane]     <= 1'b1;
        inAlPtr[lane]     <= ptr;
        inDstWrite[lane]  <= dst;
        inDstReg[lane]    <= dstReg;
        inData[lane]      <= data;
        inExecState[lane] <= state;
        inIsStore[lane]   <= isStore;
    endtask

    // Next rising edge, lanes idle unless an item is presented after
    task automatic nextCycle();
        @(posedge ctrl);
        for (int i = 0; i < LANES; i++) begin
            inValid[i] <= 1'b0;
        end
        recoveryReq <= 1'b0;
    endtask

    task automatic readBack();
        checkBusy = 1'b1;
        wait (!checkBusy);
    endtask

    task automatic drainAndCheck();
        nextCycle();
        stall <= 1'b0;
        clear <= 1'b0;
        repeat (2) nextCycle();
        readBack();
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] bits;
        wait (rst === 1'b0);

        // Plain loads, one entry without a register write
        nextCycle();
        presentItem(0, 5'd1, 1'b1, 6'd10, lcgNext(), EXEC_STATE_SUCCESS, 1'b0);
        presentItem(1, 5'd2, 1'b1, 6'd11, lcgNext(), EXEC_STATE_FAULT, 1'b0);
        nextCycle();
        presentItem(0, 5'd3, 1'b0, 6'd12, lcgNext(), EXEC_STATE_SUCCESS, 1'b1);
        presentItem(1, 5'd4, 1'b1, 6'd13, lcgNext(), EXEC_STATE_REFETCH_THIS, 1'b0);
        drainAndCheck();

        // Item held through a stall, checked during and after it
        nextCycle();
        presentItem(0, 5'd6, 1'b1, 6'd20, lcgNext(), EXEC_STATE_SUCCESS, 1'b0);
        nextCycle();
        stall <= 1'b1;
        presentItem(1, 5'd7, 1'b1, 6'd21, lcgNext(), EXEC_STATE_FAULT, 1'b0);
        repeat (3) nextCycle();
        readBack();
        nextCycle();
        stall <= 1'b0;
        drainAndCheck();

        // Clear in the update cycle
        nextCycle();
        presentItem(0, 5'd8, 1'b1, 6'd10, lcgNext(), EXEC_STATE_FAULT, 1'b0);
        presentItem(1, 5'd9, 1'b1, 6'd30, lcgNext(), EXEC_STATE_SUCCESS, 1'b1);
        nextCycle();
        clear <= 1'b1;
        nextCycle();
        clear <= 1'b0;
        drainAndCheck();

        // Wrapping range 28..2, then a request while busy
        nextCycle();
        recoveryReq  <= 1'b1;
        recoveryHead <= 5'd28;
        recoveryTail <= 5'd3;
        presentItem(0, 5'd30, 1'b1, 6'd40, lcgNext(), EXEC_STATE_SUCCESS, 1'b0);
        presentItem(1, 5'd10, 1'b1, 6'd41, lcgNext(), EXEC_STATE_SUCCESS, 1'b0);
        nextCycle();
        recoveryReq  <= 1'b1;
        recoveryHead <= 5'd0;
        recoveryTail <= 5'd31;
        presentItem(0, 5'd1, 1'b1, 6'd42, lcgNext(), EXEC_STATE_FAULT, 1'b0);
        presentItem(1, 5'd3, 1'b1, 6'd43, lcgNext(), EXEC_STATE_SUCCESS, 1'b1);
        nextCycle();
        presentItem(0, 5'd28, 1'b1, 6'd44, lcgNext(), EXEC_STATE_SUCCESS, 1'b0);
        presentItem(1, 5'd27, 1'b1, 6'd45, lcgNext(), EXEC_STATE_REFETCH_THIS, 1'b0);
        repeat (3) nextCycle();
        // Empty range drops nothing
        recoveryReq  <= 1'b1;
        recoveryHead <= 5'd7;
        recoveryTail <= 5'd7;
        nextCycle();
        presentItem(0, 5'd7, 1'b1, 6'd46, lcgNext(), EXEC_STATE_SUCCESS, 1'b0);
        presentItem(1, 5'd20, 1'b1, 6'd47, lcgNext(), EXEC_STATE_FAULT, 1'b1);
        drainAndCheck();

        // Random mix, lane pointers and registers kept distinct
        for (int c = 0; c < 200; c++) begin
            nextCycle();
            rnd = lcgNext();
            stall        <= rnd[31:29] == 3'd0;
            clear        <= rnd[28:26] == 3'd0;
            recoveryReq  <= rnd[25:23] == 3'd0;
            recoveryHead <= rnd[22:18];
            recoveryTail <= rnd[17:13];
            for (int i = 0; i < LANES; i++) begin
                bits = lcgNext();
                presentItem(i, rnd[12:8] + ActiveListPtr'(i), bits[31],
                            rnd[5:0] + PhyRegNum'(i), lcgNext(),
                            ExecState'(bits[29:28]), bits[27]);
                inValid[i] <= bits[30];
            end
        end
        drainAndCheck();

        $display("Checks finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 200) * 20);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

//--- tb.f
common/MemWbPkg.sv
hw/memWriteback/MemWritebackLane.sv
hw/memWriteback/RecoveryManager.sv
hw/memWriteback/CompletionRecorder.sv
hw/MemWritebackUnit.sv
verification/TbClock.sv
verification/TbMemWriteback.sv

//--- run.sh
#!/bin/sh
# Builds the memory write-back testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -Mdir build \
    --top-module TbMemWriteback -f tb.f

./build/VTbMemWriteback > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation passed"
